// ==== io_pkg.sv ====
package io_pkg;

    // One request from the core side of the memory bus
    typedef struct packed {
        logic        load;   // Read strobe
        logic        store;  // Write strobe
        logic [31:0] addr;   // Byte address
        logic [31:0] wdata;  // Write data, meaningful only with store
    } io_req_t;

    // Base of the I/O window in the processor address map
    localparam logic [31:0] IO_BASE = 32'h0003_2000;

    // Low address bits that select a register inside the window
    localparam int IO_WINDOW_BITS = 4;

    // Register offsets within the window
    // LED bits are write only, each one switched on by a nonzero store
    localparam logic [3:0] REG_LED0 = 4'd0;
    localparam logic [3:0] REG_LED1 = 4'd1;
    localparam logic [3:0] REG_LED2 = 4'd2;
    localparam logic [3:0] REG_LED3 = 4'd3;

    // Transmitter control and data, both write only
    localparam logic [3:0] REG_TX_EN    = 4'd4;
    localparam logic [3:0] REG_TX_BYTE  = 4'd5;

    // Status and receive registers, read only
    localparam logic [3:0] REG_TX_READY = 4'd6;
    localparam logic [3:0] REG_RX_BYTE  = 4'd7;  // Reading it clears the receive flag
    localparam logic [3:0] REG_RX_READY = 4'd8;

    // Synchronized switch inputs, one bit per offset
    localparam logic [3:0] REG_SW0 = 4'd9;
    localparam logic [3:0] REG_SW1 = 4'd10;
    localparam logic [3:0] REG_SW2 = 4'd11;
    localparam logic [3:0] REG_SW3 = 4'd12;

    // Serial frame is one start bit, this many data bits LSB first, one stop bit
    localparam int UART_DATA_BITS = 8;

endpackage

// ==== uart_rx.sv ====
module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam int idx_w = $clog2(io_pkg::UART_DATA_BITS);

    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [idx_w-1:0] last_idx = idx_w'(io_pkg::UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                            state;
    logic [cnt_w-1:0]                  bit_cnt;
    logic [idx_w-1:0]                  bit_idx;
    logic [io_pkg::UART_DATA_BITS-1:0] shift;
    logic                              rxd_meta;
    logic                              rxd_sync;
    logic                              rxd_prev;
    logic                              fall;
    logic                              bit_end;

    // The serial line is asynchronous to clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;  // Idle line level
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall    = rxd_prev && !rxd_sync;
    assign bit_end = (bit_cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= s_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (fall) begin
                        state   <= s_start;
                        bit_cnt <= '0;
                    end
                end
                s_start: begin
                    // Half a bit after the edge we sit in the middle of the start bit
                    if (bit_cnt == half_cnt) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? s_idle : s_data;  // High here means a glitch
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == last_idx) begin
                            state <= s_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (bit_end) begin
                        bit_cnt  <= '0;
                        rx_valid <= rxd_sync;  // A low stop bit drops the frame
                        state    <= s_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Bits arrive LSB first, so each new one enters at the top
    always_ff @(posedge clk) begin
        if (state == s_data && bit_end) begin
            shift <= {rxd_sync, shift[io_pkg::UART_DATA_BITS-1:1]};
        end
    end

    assign rx_byte = shift;

    // A frame lasts many cycles, so two pulses back to back mean a broken FSM
    a_rx_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    ) else $error("rx_valid high on two consecutive cycles");

endmodule

// ==== uart_tx.sv ====
module uart_tx #(
    parameter int clks_per_bit = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx_ready,
    output logic       txd
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam int idx_w = $clog2(io_pkg::UART_DATA_BITS);

    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [idx_w-1:0] last_idx = idx_w'(io_pkg::UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t                            state;
    logic [cnt_w-1:0]                  bit_cnt;
    logic [idx_w-1:0]                  bit_idx;
    logic [io_pkg::UART_DATA_BITS-1:0] shift;
    logic                              txd_q;
    logic                              bit_end;

    assign bit_end = (bit_cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= s_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd_q   <= 1'b1;
        end else begin
            case (state)
                s_idle: begin
                    if (tx_start) begin
                        state   <= s_start;
                        bit_cnt <= '0;
                        txd_q   <= 1'b0;  // Start bit
                    end
                end
                s_start: begin
                    if (bit_end) begin
                        state   <= s_data;
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        txd_q   <= shift[0];
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == last_idx) begin
                            state <= s_stop;
                            txd_q <= 1'b1;  // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd_q   <= shift[1];  // Next bit, ahead of the shift below
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (bit_end) begin
                        state   <= s_idle;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && tx_start) begin
            shift <= tx_byte;
        end else if (state == s_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    assign tx_ready = (state == s_idle);
    assign txd      = txd_q;

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n) tx_ready |-> txd
    ) else $error("Serial line low while transmitter reports ready");

endmodule

// ==== gpio.sv ====
module gpio #(
    parameter int clks_per_bit = 868
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            enabled,
    input  io_pkg::io_req_t req,
    output logic [31:0]     rdata,
    output logic [3:0]      led,
    input  logic [3:0]      sw,
    input  logic            uart_txd_in,   // Named from the host side, this is our receive line
    output logic            uart_rxd_out
);

    logic [io_pkg::IO_WINDOW_BITS-1:0] offset;
    logic                              store_hit;
    logic                              load_hit;
    logic                              rx_clear;
    logic [31:0]                       read_data;

    logic       tx_en;
    logic [7:0] tx_byte;
    logic       tx_ready;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_pending;
    logic [3:0] sw_meta;
    logic [3:0] sw_sync;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) uart_rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (uart_txd_in),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) uart_tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_en),
        .tx_ready (tx_ready),
        .txd      (uart_rxd_out)
    );

    assign offset    = req.addr[io_pkg::IO_WINDOW_BITS-1:0];
    assign store_hit = enabled && req.store;
    assign load_hit  = enabled && req.load && !req.store;  // Store wins the decode
    assign rx_clear  = load_hit && (offset == io_pkg::REG_RX_BYTE);

    // Switches are board inputs with no relation to clk
    always_ff @(posedge clk) begin
        sw_meta <= sw;
        sw_sync <= sw_meta;
    end

    // Keep the byte until the next frame so software can read it late
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_data <= rx_byte;
        end
    end

    always_comb begin
        case (offset)
            io_pkg::REG_TX_READY: read_data = {31'b0, tx_ready};
            io_pkg::REG_RX_BYTE:  read_data = {24'b0, rx_data};
            io_pkg::REG_RX_READY: read_data = {31'b0, rx_pending};
            io_pkg::REG_SW0:      read_data = {31'b0, sw_sync[0]};
            io_pkg::REG_SW1:      read_data = {31'b0, sw_sync[1]};
            io_pkg::REG_SW2:      read_data = {31'b0, sw_sync[2]};
            io_pkg::REG_SW3:      read_data = {31'b0, sw_sync[3]};
            default:              read_data = '0;  // Write-only and unmapped offsets
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led        <= '0;
            tx_en      <= 1'b0;
            tx_byte    <= '0;
            rx_pending <= 1'b0;
            rdata      <= '0;
        end else begin
            if (store_hit) begin
                case (offset)
                    io_pkg::REG_LED0:    led[0]  <= |req.wdata;
                    io_pkg::REG_LED1:    led[1]  <= |req.wdata;
                    io_pkg::REG_LED2:    led[2]  <= |req.wdata;
                    io_pkg::REG_LED3:    led[3]  <= |req.wdata;
                    io_pkg::REG_TX_EN:   tx_en   <= |req.wdata;
                    io_pkg::REG_TX_BYTE: tx_byte <= req.wdata[7:0];
                    default: ;
                endcase
            end else if (load_hit) begin
                rdata <= read_data;  // Held until the next load in the window
            end

            // A byte landing on the same cycle as the read must not be lost
            if (rx_valid) begin
                rx_pending <= 1'b1;
            end else if (rx_clear) begin
                rx_pending <= 1'b0;
            end
        end
    end

    a_no_load_and_store: assert property (
        @(posedge clk) disable iff (!rst_n) enabled |-> !(req.load && req.store)
    ) else $error("Load and store strobes both high on an I/O request");

endmodule

// ==== io_subsystem.sv ====
module io_subsystem #(
    parameter int clks_per_bit = 868
) (
    input  logic            clk,
    input  logic            rst_n,
    input  io_pkg::io_req_t req,
    output logic [31:0]     rdata,
    output logic [3:0]      led,
    input  logic [3:0]      sw,
    input  logic            uart_txd_in,
    output logic            uart_rxd_out
);

    localparam logic [31:0] io_page = io_pkg::IO_BASE >> io_pkg::IO_WINDOW_BITS;

    logic [31:0] req_page;
    logic        in_window;

    // Drop the register select bits so only the page of the address is compared
    assign req_page  = req.addr >> io_pkg::IO_WINDOW_BITS;
    assign in_window = (req_page == io_page);

    // The register file only trusts the low address bits when enabled is high
    gpio #(
        .clks_per_bit(clks_per_bit)
    ) gpio_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .enabled      (in_window),
        .req          (req),
        .rdata        (rdata),
        .led          (led),
        .sw           (sw),
        .uart_txd_in  (uart_txd_in),
        .uart_rxd_out (uart_rxd_out)
    );

endmodule

// ==== io_subsystem_tb.sv ====
module io_subsystem_tb;

    localparam int clks_per_bit = 8;
    localparam int poll_limit   = 40 * clks_per_bit;
    localparam int num_bytes    = 4;
    localparam int num_patterns = 3;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_poll,
        op_switch
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] wdata;       // Store data, or the switch pattern
        logic [31:0] expect_val;  // Read value, or the led port after a store
    } entry_t;

    logic            clk;
    logic            rst_n;
    io_pkg::io_req_t req;
    logic [31:0]     rdata;
    logic [3:0]      led;
    logic [3:0]      sw;
    logic            serial_loop;  // Transmit line fed straight back into the receiver

    string       names[$];
    entry_t      steps[$];
    logic [3:0]  led_model;
    logic [31:0] rdata_model;
    logic [7:0]  tx_bytes[num_bytes];
    logic [3:0]  sw_patterns[num_patterns];

    io_subsystem #(
        .clks_per_bit(clks_per_bit)
    ) io_subsystem_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .rdata        (rdata),
        .led          (led),
        .sw           (sw),
        .uart_txd_in  (serial_loop),
        .uart_rxd_out (serial_loop)
    );

    always #20 clk = ~clk;

    function automatic io_pkg::io_req_t bus_request(input logic load, input logic store,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] wdata);
        io_pkg::io_req_t r;
        r.load  = load;
        r.store = store;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic logic [31:0] window_addr(input logic [3:0] offset);
        return io_pkg::IO_BASE | {28'b0, offset};
    endfunction

    // The window covers one block of registers upward from the base
    function automatic logic in_window(input logic [31:0] addr);
        return addr >= io_pkg::IO_BASE &&
               addr < io_pkg::IO_BASE + (32'd1 << io_pkg::IO_WINDOW_BITS);
    endfunction

    function automatic void push_entry(input string name, input op_t op,
                                       input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [31:0] expect_val);
        entry_t e;
        e.op         = op;
        e.addr       = addr;
        e.wdata      = wdata;
        e.expect_val = expect_val;
        names.push_back(name);
        steps.push_back(e);
    endfunction

    // Any nonzero word lights the addressed LED, a store outside the window does nothing
    function automatic void store_step(input string name, input logic [31:0] addr,
                                       input logic [31:0] data);
        if (in_window(addr) && addr[3:0] <= io_pkg::REG_LED3) begin
            led_model[addr[1:0]] = |data;
        end
        push_entry(name, op_write, addr, data, {28'b0, led_model});
    endfunction

    function automatic void load_step(input string name, input logic [31:0] addr,
                                      input logic [31:0] expected);
        if (in_window(addr)) begin
            rdata_model = expected;
        end
        push_entry(name, op_read, addr, 32'b0, rdata_model);  // Stray loads leave rdata held
    endfunction

    function automatic void poll_step(input string name, input logic [3:0] offset,
                                      input logic [31:0] expected);
        rdata_model = expected;
        push_entry(name, op_poll, window_addr(offset), 32'b0, expected);
    endfunction

    function automatic void build_table();
        // Reset state
        load_step("reset tx ready", window_addr(io_pkg::REG_TX_READY), 32'd1);
        load_step("reset rx ready", window_addr(io_pkg::REG_RX_READY), 32'd0);

        store_step("led0 on", window_addr(io_pkg::REG_LED0), 32'h0000_0001);
        store_step("led1 on from bit 31", window_addr(io_pkg::REG_LED1), 32'h8000_0000);
        store_step("led2 on", window_addr(io_pkg::REG_LED2), 32'hdead_beef);
        store_step("led3 on", window_addr(io_pkg::REG_LED3), 32'h0000_0005);
        store_step("led0 off", window_addr(io_pkg::REG_LED0), 32'h0);
        store_step("led2 off", window_addr(io_pkg::REG_LED2), 32'h0);
        load_step("led1 is write only", window_addr(io_pkg::REG_LED1), 32'h0);
        store_step("tx byte preset", window_addr(io_pkg::REG_TX_BYTE), 32'h0000_00a5);
        load_step("tx byte is write only", window_addr(io_pkg::REG_TX_BYTE), 32'h0);

        for (int p = 0; p < num_patterns; p++) begin
            push_entry($sformatf("switch pattern %0d", p), op_switch, 32'h0,
                       {28'b0, sw_patterns[p]}, 32'h0);
            for (int b = 0; b < 4; b++) begin
                load_step($sformatf("switch %0d of pattern %0d", b, p),
                          window_addr(4'(io_pkg::REG_SW0 + b)), {31'b0, sw_patterns[p][b]});
            end
            for (int off = 13; off < 16; off++) begin
                load_step($sformatf("unmapped offset %0d", off), window_addr(4'(off)), 32'h0);
            end
        end

        for (int i = 0; i < num_bytes; i++) begin
            store_step($sformatf("byte %0d load", i), window_addr(io_pkg::REG_TX_BYTE),
                       {24'b0, tx_bytes[i]});
            store_step($sformatf("byte %0d start", i), window_addr(io_pkg::REG_TX_EN), 32'd1);
            load_step($sformatf("byte %0d tx busy", i), window_addr(io_pkg::REG_TX_READY), 32'd0);
            store_step($sformatf("byte %0d stop", i), window_addr(io_pkg::REG_TX_EN), 32'd0);
            poll_step($sformatf("byte %0d arrival", i), io_pkg::REG_RX_READY, 32'd1);
            load_step($sformatf("byte %0d received", i), window_addr(io_pkg::REG_RX_BYTE),
                      {24'b0, tx_bytes[i]});
            load_step($sformatf("byte %0d flag cleared", i), window_addr(io_pkg::REG_RX_READY),
                      32'd0);
            poll_step($sformatf("byte %0d tx done", i), io_pkg::REG_TX_READY, 32'd1);
        end

        // Neighbouring pages must not reach the register file
        store_step("stray store above", io_pkg::IO_BASE + 32'h100, 32'hffff_ffff);
        store_step("stray store below", io_pkg::IO_BASE - 32'h10 + 32'h2, 32'h1);
        load_step("last byte again", window_addr(io_pkg::REG_RX_BYTE),
                  {24'b0, tx_bytes[num_bytes-1]});
        load_step("stray load tx ready", io_pkg::IO_BASE + 32'h100 + 32'h6, 32'h0);
        load_step("stray load rx ready", io_pkg::IO_BASE + 32'h1000 + 32'h8, 32'h0);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic run_entry(input string name, input entry_t e);
        int waited;
        waited = 0;
        @(posedge clk);
        #5;
        case (e.op)
            op_write: begin
                req = bus_request(1'b0, 1'b1, e.addr, e.wdata);
                @(posedge clk);
                #5;
                req = bus_request(1'b0, 1'b0, 32'h0, 32'h0);
                check_value(name, e.expect_val, {28'b0, led});  // LED updates one cycle later
            end
            op_read: begin
                req = bus_request(1'b1, 1'b0, e.addr, 32'h0);
                @(posedge clk);
                #5;
                req = bus_request(1'b0, 1'b0, 32'h0, 32'h0);
                check_value(name, e.expect_val, rdata);
            end
            op_poll: begin
                req = bus_request(1'b1, 1'b0, e.addr, 32'h0);  // Load held on every cycle
                @(posedge clk);
                #5;
                while (rdata !== e.expect_val && waited < poll_limit) begin
                    @(posedge clk);
                    #5;
                    waited++;
                end
                req = bus_request(1'b0, 1'b0, 32'h0, 32'h0);
                if (rdata !== e.expect_val) begin
                    $display("Wait for %s never completed within %0d cycles", name, poll_limit);
                    $display("Simulation failed");
                    $fatal(1, "Poll timeout in %s", name);
                end
            end
            op_switch: begin
                sw = e.wdata[3:0];
                repeat (3) @(posedge clk);  // Two synchronizer flops plus margin
            end
            default: ;
        endcase
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = bus_request(1'b0, 1'b0, 32'h0, 32'h0);
        sw    = 4'h0;

        void'($urandom(32'h1471));
        for (int i = 0; i < num_bytes; i++) begin
            tx_bytes[i] = 8'($urandom);
        end
        for (int p = 0; p < num_patterns; p++) begin
            sw_patterns[p] = 4'($urandom);
        end
        led_model   = 4'h0;
        rdata_model = 32'h0;
        build_table();

        repeat (5) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_value("reset led port", 32'h0, {28'b0, led});
        check_value("reset serial line", 32'h1, {31'b0, serial_loop});  // Idle line is high

        for (int i = 0; i < steps.size(); i++) begin
            run_entry(names[i], steps[i]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
io_pkg.sv
uart_rx.sv
uart_tx.sv
gpio.sv
io_subsystem.sv
io_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - io_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - gpio.sv
  - io_subsystem.sv
  - target: test
    files:
      - io_subsystem_tb.sv
